//--- files.f
logic/conv1x1_pkg.sv
logic/weight_store.sv
logic/pixel_sequencer.sv
logic/mac_lane.sv
logic/result_serializer.sv
logic/conv1x1_layer.sv
bench/conv1x1_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = conv1x1_tb
FILELIST   = files.f
OBJ_DIR    = obj_dir
PASS_MSG   = Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/conv1x1_tb.sv
`timescale 1ns/100ps

module conv1x1_tb import conv1x1_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_LIMIT = 200;
	localparam int FIRST_OUT_DELAY = 3;
	localparam int SET_HAND = 0;
	localparam int SET_MIN = 1;
	localparam int SET_RANDOM = 2;
	localparam logic [15:0] LFSR_SEED = 16'd52139;
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

	logic clk;
	logic reset;
	logic weight_valid;
	wgt_t weight_data;
	logic weights_ready;
	logic pixel_valid;
	pxl_t pixel_data;
	logic out_valid;
	pxl_t out_data;

	// Weights the DUT holds, and the pixel being sent
	wgt_t model_w [CH_OUT][CH_IN];
	pxl_t cur_pixel [CH_IN];

	pxl_t exp_data_q [$];
	int exp_cycle_q [$];

	logic [15:0] lfsr_state;
	int cycle_cnt = 0;
	int value_errors = 0;
	int protocol_errors = 0;
	int timeout_errors = 0;
	int outputs_seen = 0;

	conv1x1_layer i_dut (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight_data  (weight_data),
		.weights_ready(weights_ready),
		.pixel_valid  (pixel_valid),
		.pixel_data   (pixel_data),
		.out_valid    (out_valid),
		.out_data     (out_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Random numbers and the reference model
	//////////////////////////////////////////////////////////////////////

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr_state[0]};
			if (lfsr_state[0]) begin
				lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
			end else begin
				lfsr_state = lfsr_state >> 1;
			end
		end
		return value;
	endfunction

	// Dot product over input channels, scaled and clamped to 8 bits
	function automatic pxl_t ref_channel(input int oc);
		int sum;
		int scaled;
		sum = 0;
		for (int ic = 0; ic < CH_IN; ic++) begin
			sum += int'(cur_pixel[ic]) * int'(model_w[oc][ic]);
		end
		scaled = sum >>> OUT_SHIFT;
		if (scaled > 127) begin
			return pxl_t'(127);
		end else if (scaled < -128) begin
			return pxl_t'(-128);
		end
		return pxl_t'(scaled);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_pixel(input string name, input pxl_t got, input pxl_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %0d expected %0d", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %b expected %b", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_cycle(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[ERROR] %0t ns %s: got %0d expected %0d", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// Output side, sampled away from the rising edge
	initial begin
		pxl_t exp_data;
		int exp_cycle;
		forever begin
			@(negedge clk);
			if (!reset && out_valid === 1'b1) begin
				if (exp_data_q.size() == 0) begin
					$display("Output seen at %0t ns while no result was pending", $time);
					protocol_errors++;
				end else begin
					exp_data = exp_data_q.pop_front();
					exp_cycle = exp_cycle_q.pop_front();
					check_pixel("out_data", out_data, exp_data);
					check_cycle("out_valid cycle", cycle_cnt, exp_cycle);
					outputs_seen++;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			pixel_valid = 1'b0;
			weight_valid = 1'b0;
		end
	endtask

	task automatic fill_weights(input int set_sel);
		for (int oc = 0; oc < CH_OUT; oc++) begin
			for (int ic = 0; ic < CH_IN; ic++) begin
				case (set_sel)
					SET_HAND: begin
						model_w[oc][ic] = wgt_t'((((oc % 2) == 0) ? 1 : -1) *
							(16 * (oc + 1) - 4 * ic));
					end
					SET_MIN: model_w[oc][ic] = wgt_t'(-128);
					default: model_w[oc][ic] = wgt_t'(rand_bits(WGT_WIDTH));
				endcase
			end
		end
	endtask

	// Output-channel-major, ready must stay low until the last word
	task automatic load_weights();
		for (int k = 0; k < W_COUNT; k++) begin
			@(posedge clk);
			#1;
			if (k > 0) begin
				check_flag("weights_ready", weights_ready, 1'b0);
			end
			weight_valid = 1'b1;
			weight_data = model_w[k / CH_IN][k % CH_IN];
		end
		@(posedge clk);
		#1;
		weight_valid = 1'b0;
		check_flag("weights_ready", weights_ready, 1'b1);
	endtask

	// Leaves pixel_valid high so the next pixel can follow directly
	task automatic send_pixel(input bit expect_out, input bit gaps);
		int gap;
		for (int ic = 0; ic < CH_IN; ic++) begin
			gap = gaps ? int'(rand_bits(2)) : 0;
			repeat (gap) begin
				@(posedge clk);
				#1;
				pixel_valid = 1'b0;
			end
			@(posedge clk);
			#1;
			pixel_valid = 1'b1;
			pixel_data = cur_pixel[ic];
		end
		if (expect_out) begin
			for (int oc = 0; oc < CH_OUT; oc++) begin
				exp_data_q.push_back(ref_channel(oc));
				exp_cycle_q.push_back(cycle_cnt + FIRST_OUT_DELAY + oc);
			end
		end
	endtask

	task automatic random_pixel();
		for (int ic = 0; ic < CH_IN; ic++) begin
			cur_pixel[ic] = pxl_t'(rand_bits(PXL_WIDTH));
		end
	endtask

	task automatic set_pixel(input pxl_t value);
		for (int ic = 0; ic < CH_IN; ic++) begin
			cur_pixel[ic] = value;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_data_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_data_q.size() != 0) begin
			$display("Timed out with %0d outputs still pending", exp_data_q.size());
			timeout_errors++;
			exp_data_q.delete();
			exp_cycle_q.delete();
		end
		idle_cycles(2);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		weight_valid = 1'b0;
		weight_data = '0;
		pixel_valid = 1'b0;
		pixel_data = '0;
		lfsr_state = LFSR_SEED;

		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			#1;
			check_flag("out_valid", out_valid, 1'b0);
			check_flag("weights_ready", weights_ready, 1'b0);
		end
		reset = 1'b0;
		@(posedge clk);
		#1;
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("weights_ready", weights_ready, 1'b0);

		// Dropped before any weights are in
		set_pixel(pxl_t'(50));
		send_pixel(1'b0, 1'b0);
		idle_cycles(12);

		// Hand-picked cases
		fill_weights(SET_HAND);
		load_weights();
		set_pixel(pxl_t'(1));
		send_pixel(1'b1, 1'b0);
		idle_cycles(1);
		wait_drain();
		set_pixel(pxl_t'(0));
		cur_pixel[5] = pxl_t'(120);
		send_pixel(1'b1, 1'b0);
		idle_cycles(1);
		wait_drain();
		set_pixel(pxl_t'(127));
		send_pixel(1'b1, 1'b0);
		idle_cycles(1);
		wait_drain();

		// Saturation at both ends
		fill_weights(SET_MIN);
		load_weights();
		set_pixel(pxl_t'(-128));
		send_pixel(1'b1, 1'b0);
		set_pixel(pxl_t'(127));
		send_pixel(1'b1, 1'b0);
		idle_cycles(1);
		wait_drain();

		// Random traffic, back-to-back then with gaps
		fill_weights(SET_RANDOM);
		load_weights();
		for (int p = 0; p < 150; p++) begin
			random_pixel();
			send_pixel(1'b1, 1'b0);
		end
		idle_cycles(1);
		wait_drain();
		for (int p = 0; p < 150; p++) begin
			random_pixel();
			send_pixel(1'b1, 1'b1);
			idle_cycles(int'(rand_bits(2)));
		end
		idle_cycles(1);
		wait_drain();

		// New weights take effect after a reload
		fill_weights(SET_HAND);
		load_weights();
		for (int p = 0; p < 20; p++) begin
			random_pixel();
			send_pixel(1'b1, 1'b0);
		end
		idle_cycles(1);
		wait_drain();

		$display("Errors: %0d value, %0d protocol, %0d timeout, %0d outputs checked",
			value_errors, protocol_errors, timeout_errors, outputs_seen);
		if (value_errors + protocol_errors + timeout_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- logic/conv1x1_layer.sv
`timescale 1ns/100ps

module conv1x1_layer import conv1x1_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic weight_valid,
	input  wgt_t weight_data,
	output logic weights_ready,
	input  logic pixel_valid,
	input  pxl_t pixel_data,
	output logic out_valid,
	output pxl_t out_data
);

	wgt_t lane_weights [CH_OUT];
	acc_t lane_results [CH_OUT];

	// Lane 0 speaks for all of them
	logic lane_done;

	logic seq_valid;
	pxl_t seq_pixel;
	ch_idx_t seq_ch_idx;
	logic seq_first;
	logic seq_last;

	weight_store u_weight_store (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight_data  (weight_data),
		.seq_ch_idx   (seq_ch_idx),
		.lane_weights (lane_weights),
		.weights_ready(weights_ready)
	);

	pixel_sequencer u_pixel_sequencer (
		.clk          (clk),
		.reset        (reset),
		.pixel_valid  (pixel_valid),
		.pixel_data   (pixel_data),
		.weights_ready(weights_ready),
		.seq_valid    (seq_valid),
		.seq_pixel    (seq_pixel),
		.seq_ch_idx   (seq_ch_idx),
		.seq_first    (seq_first),
		.seq_last     (seq_last)
	);

	//////////////////////////////////////////////////////////////////////
	// One lane per output channel
	//////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < CH_OUT; g++) begin : g_lane
		if (g == 0) begin : g_lead
			mac_lane u_mac_lane (
				.clk      (clk),
				.reset    (reset),
				.seq_valid(seq_valid),
				.seq_pixel(seq_pixel),
				.seq_first(seq_first),
				.seq_last (seq_last),
				.weight   (lane_weights[g]),
				.result   (lane_results[g]),
				.done     (lane_done)
			);
		end else begin : g_follow
			mac_lane u_mac_lane (
				.clk      (clk),
				.reset    (reset),
				.seq_valid(seq_valid),
				.seq_pixel(seq_pixel),
				.seq_first(seq_first),
				.seq_last (seq_last),
				.weight   (lane_weights[g]),
				.result   (lane_results[g]),
				.done     ()
			);
		end
	end

	result_serializer u_result_serializer (
		.clk         (clk),
		.reset       (reset),
		.lane_done   (lane_done),
		.lane_results(lane_results),
		.out_valid   (out_valid),
		.out_data    (out_data)
	);

endmodule

//--- logic/result_serializer.sv
`timescale 1ns/100ps

module result_serializer import conv1x1_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic lane_done,
	input  acc_t lane_results [CH_OUT],
	output logic out_valid,
	output pxl_t out_data
);

	localparam logic [OUT_IDX_WIDTH-1:0] LAST_IDX = OUT_IDX_WIDTH'(CH_OUT - 1);

	acc_t buffer [CH_OUT];
	logic busy;
	logic [OUT_IDX_WIDTH-1:0] idx;

	// Shift down, then clamp to the signed pixel range
	function automatic pxl_t scale_sat(input acc_t sum);
		acc_t shifted;
		shifted = sum >>> OUT_SHIFT;
		if (shifted > acc_t'(PXL_MAX)) begin
			scale_sat = pxl_t'(PXL_MAX);
		end else if (shifted < acc_t'(PXL_MIN)) begin
			scale_sat = pxl_t'(PXL_MIN);
		end else begin
			scale_sat = pxl_t'(shifted);
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Channel sequencing
	//////////////////////////////////////////////////////////////////////

	// Channel 0 leaves with the load, the rest follow from the buffer
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			out_valid <= 1'b0;
			idx <= '0;
		end else if (lane_done) begin
			busy <= 1'b1;
			out_valid <= 1'b1;
			idx <= OUT_IDX_WIDTH'(1);
		end else if (busy) begin
			out_valid <= 1'b1;
			idx <= idx + 1'b1;
			if (idx == LAST_IDX) begin
				busy <= 1'b0;
			end
		end else begin
			out_valid <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data path
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (lane_done) begin
			buffer <= lane_results;
			out_data <= scale_sat(lane_results[0]);
		end else if (busy) begin
			out_data <= scale_sat(buffer[idx]);
		end
	end

	// A pixel needs CH_IN cycles, so the previous one is always drained
	a_no_overlap: assert property (
		@(posedge clk) disable iff (reset)
		lane_done |-> !busy
	);

endmodule

//--- logic/mac_lane.sv
`timescale 1ns/100ps

module mac_lane import conv1x1_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic seq_valid,
	input  pxl_t seq_pixel,
	input  logic seq_first,
	input  logic seq_last,
	input  wgt_t weight,
	output acc_t result,
	output logic done
);

	logic signed [PROD_WIDTH-1:0] product;
	acc_t product_ext;
	acc_t acc;
	acc_t acc_next;

	//////////////////////////////////////////////////////////////////////
	// Multiply and add
	//////////////////////////////////////////////////////////////////////

	// Signed 8x8 product, sign extended to the accumulator
	assign product = seq_pixel * weight;
	assign product_ext = acc_t'(product);

	// First channel restarts the running sum
	always_comb begin
		if (seq_first) begin
			acc_next = product_ext;
		end else begin
			acc_next = acc + product_ext;
		end
	end

	always_ff @(posedge clk) begin
		if (seq_valid) begin
			acc <= acc_next;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Result register
	//////////////////////////////////////////////////////////////////////

	// Final sum lands one cycle after the last channel
	always_ff @(posedge clk) begin
		if (seq_valid && seq_last) begin
			result <= acc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= seq_valid & seq_last;
		end
	end

endmodule

//--- logic/pixel_sequencer.sv
`timescale 1ns/100ps

module pixel_sequencer import conv1x1_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    pixel_valid,
	input  pxl_t    pixel_data,
	input  logic    weights_ready,
	output logic    seq_valid,
	output pxl_t    seq_pixel,
	output ch_idx_t seq_ch_idx,
	output logic    seq_first,
	output logic    seq_last
);

	localparam ch_idx_t LAST_CH = CH_IDX_WIDTH'(CH_IN - 1);

	// Channel index of the next accepted word
	ch_idx_t ch_cnt;
	logic accept;

	// Words before the weights are in are dropped
	assign accept = pixel_valid & weights_ready;

	//////////////////////////////////////////////////////////////////////
	// Channel tracking
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ch_cnt <= '0;
		end else if (accept) begin
			if (ch_cnt == LAST_CH) begin
				ch_cnt <= '0;
			end else begin
				ch_cnt <= ch_cnt + 1'b1;
			end
		end
	end

	// Qualifiers, low when nothing was accepted
	always_ff @(posedge clk) begin
		if (reset) begin
			seq_valid <= 1'b0;
			seq_first <= 1'b0;
			seq_last <= 1'b0;
		end else begin
			seq_valid <= accept;
			seq_first <= accept && (ch_cnt == '0);
			seq_last <= accept && (ch_cnt == LAST_CH);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Word register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (accept) begin
			seq_pixel <= pixel_data;
			seq_ch_idx <= ch_cnt;
		end
	end

	// A pixel has more than one channel, so the marks never coincide
	a_first_last_excl: assert property (
		@(posedge clk) disable iff (reset)
		!(seq_first && seq_last)
	);

endmodule

//--- logic/weight_store.sv
`timescale 1ns/100ps

module weight_store import conv1x1_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    weight_valid,
	input  wgt_t    weight_data,
	input  ch_idx_t seq_ch_idx,
	output wgt_t    lane_weights [CH_OUT],
	output logic    weights_ready
);

	localparam logic [WGT_CNT_WIDTH-1:0] LAST_WGT = WGT_CNT_WIDTH'(W_COUNT - 1);

	// Flat store, entry oc*CH_IN + ic
	wgt_t weights [W_COUNT];

	logic [WGT_CNT_WIDTH-1:0] load_cnt;

	//////////////////////////////////////////////////////////////////////
	// Serial load
	//////////////////////////////////////////////////////////////////////

	// A word taken while ready starts a fresh set at entry 0
	always_ff @(posedge clk) begin
		if (reset) begin
			load_cnt <= '0;
			weights_ready <= 1'b0;
		end else if (weight_valid) begin
			if (load_cnt == LAST_WGT) begin
				load_cnt <= '0;
				weights_ready <= 1'b1;
			end else begin
				load_cnt <= load_cnt + 1'b1;
				weights_ready <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (weight_valid) begin
			weights[int'(load_cnt)] <= weight_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Lane read
	//////////////////////////////////////////////////////////////////////

	// One weight per output channel for the channel in flight
	always_comb begin
		for (int oc = 0; oc < CH_OUT; oc++) begin
			lane_weights[oc] = weights[oc * CH_IN + int'(seq_ch_idx)];
		end
	end

	// Counter wraps before it leaves the store
	a_load_cnt_range: assert property (
		@(posedge clk) disable iff (reset)
		load_cnt < WGT_CNT_WIDTH'(W_COUNT)
	);

endmodule

//--- logic/conv1x1_pkg.sv
package conv1x1_pkg;

	//////////////////////////////////////////////////////////////////////
	// Word widths
	//////////////////////////////////////////////////////////////////////

	localparam int PXL_WIDTH = 8;
	localparam int WGT_WIDTH = 8;

	// Holds CH_IN full-scale signed products with headroom
	localparam int ACC_WIDTH = 20;

	// Full product of one pixel and one weight
	localparam int PROD_WIDTH = PXL_WIDTH + WGT_WIDTH;

	//////////////////////////////////////////////////////////////////////
	// Layer shape
	//////////////////////////////////////////////////////////////////////

	localparam int CH_IN = 8;
	localparam int CH_OUT = 4;
	localparam int CH_IDX_WIDTH = 3;

	// Total weights in one load, output-channel-major
	localparam int W_COUNT = CH_OUT * CH_IN;

	// One spare bit so an out-of-range count is visible
	localparam int WGT_CNT_WIDTH = $clog2(W_COUNT) + 1;

	// Serializer channel counter
	localparam int OUT_IDX_WIDTH = $clog2(CH_OUT);

	//////////////////////////////////////////////////////////////////////
	// Output scaling
	//////////////////////////////////////////////////////////////////////

	localparam int OUT_SHIFT = 4;
	localparam int PXL_MAX = (2 ** (PXL_WIDTH - 1)) - 1;
	localparam int PXL_MIN = -(2 ** (PXL_WIDTH - 1));

	typedef logic signed [PXL_WIDTH-1:0] pxl_t;
	typedef logic signed [WGT_WIDTH-1:0] wgt_t;
	typedef logic signed [ACC_WIDTH-1:0] acc_t;
	typedef logic [CH_IDX_WIDTH-1:0] ch_idx_t;

endpackage
